//--- hw/debug_module.sv
`timescale 1ns/100ps

module debug_module import dm_reg_pkg::*, dm_hart_pkg::*; (
    input  logic                                 clk,
    input  logic                                 rst,
    // DMI
    input  logic                                 dmi_req_valid,
    input  dmi_op_e                              dmi_req_op,
    input  logic [DMI_ADDR_W-1:0]                dmi_req_addr,
    input  logic [DMI_DATA_W-1:0]                dmi_req_data,
    output logic                                 dmi_resp_valid,
    output logic [DMI_DATA_W-1:0]                dmi_resp_data,
    output dmi_resp_e                            dmi_resp_status,
    // Harts
    output logic [NUM_HARTS-1:0]                 halt_req,
    input  logic [NUM_HARTS-1:0]                 halt_ack,
    output logic [NUM_HARTS-1:0]                 resume_req,
    input  logic [NUM_HARTS-1:0]                 resume_ack,
    output logic [NUM_HARTS-1:0]                 reset_req,
    input  logic [NUM_HARTS-1:0]                 reset_ack,
    input  logic [NUM_HARTS-1:0]                 running,
    output logic [NUM_HARTS-1:0]                 reg_req,
    input  logic [NUM_HARTS-1:0]                 reg_ack,
    output logic                                 reg_write,
    output logic [REG_NUM_W-1:0]                 reg_num,
    output logic [DMI_DATA_W-1:0]                reg_wdata,
    input  logic [NUM_HARTS-1:0][DMI_DATA_W-1:0] reg_rdata
);

    logic                  ctrl_write;
    logic                  haltreq;
    logic                  resumereq;
    logic                  hartreset;
    logic                  ackhavereset;
    logic [HARTSEL_W-1:0]  hartsel;
    logic                  cmd_write;
    logic [DMI_DATA_W-1:0] cmd_word;
    logic                  cmderr_clear;
    logic [DMI_DATA_W-1:0] data0;
    logic                  sel_halted;
    logic                  sel_running;
    logic                  sel_resumeack;
    logic                  sel_havereset;
    logic                  sel_nonexistent;
    logic [NUM_HARTS-1:0]  halted_harts;
    logic                  busy;
    cmderr_e               cmderr;
    logic                  data0_load;
    logic [DMI_DATA_W-1:0] data0_value;

    dm_dmi_regs u_regs (.*, .dmactive());   // dmactive has no consumer here

    dm_hart_ctrl u_hart_ctrl (.*);

    dm_abstract_cmd u_abstract_cmd (.*);

endmodule

//--- hw/dm_abstract_cmd.sv
`timescale 1ns/100ps

module dm_abstract_cmd import dm_reg_pkg::*, dm_hart_pkg::*; (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 cmd_write,
    input  logic [DMI_DATA_W-1:0]                cmd_word,
    input  logic                                 cmderr_clear,
    input  logic [DMI_DATA_W-1:0]                data0,
    input  logic [HARTSEL_W-1:0]                 hartsel,
    input  logic                                 sel_halted,
    input  logic                                 sel_nonexistent,
    input  logic [NUM_HARTS-1:0]                 reg_ack,
    input  logic [NUM_HARTS-1:0][DMI_DATA_W-1:0] reg_rdata,
    output logic                                 busy,
    output cmderr_e                              cmderr,
    output logic [NUM_HARTS-1:0]                 reg_req,
    output logic                                 reg_write,
    output logic [REG_NUM_W-1:0]                 reg_num,
    output logic [DMI_DATA_W-1:0]                reg_wdata,
    output logic                                 data0_load,
    output logic [DMI_DATA_W-1:0]                data0_value
);

    typedef enum logic {CMD_IDLE, CMD_ACCESS} state_e;

    state_e                state;
    logic [HART_IDX_W-1:0] hart_idx;
    cmd_type_e             cmd_type;
    logic [2:0]            aar_size;
    logic [REG_NUM_W-1:0]  regno;
    logic                  regno_ok;

    assign cmd_type = cmd_type_e'(cmd_word[CMD_TYPE_LSB +: 8]);
    assign aar_size = cmd_word[AAR_SIZE_LSB +: 3];
    assign regno    = cmd_word[AAR_REGNO_LSB +: REG_NUM_W];
    assign regno_ok = regno inside {REG_DCSR, REG_DPC, REG_DSCRATCH0, REG_DSCRATCH1};

    assign busy = (state == CMD_ACCESS);
    assign reg_req = busy ? (NUM_HARTS'(1) << hart_idx) : '0;
    assign data0_load = busy && reg_ack[hart_idx] && !reg_write;   // Lands as busy drops
    assign data0_value = reg_rdata[hart_idx];

    //////////////////////////////////////////////////////////////////////
    // Command checks and access sequence
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= CMD_IDLE;
            cmderr <= CMDERR_NONE;
        end else begin
            if (cmderr_clear) cmderr <= CMDERR_NONE;
            case (state)
                CMD_IDLE: begin
                    if (cmd_write && (cmderr == CMDERR_NONE)) begin
                        if (cmd_type != CMD_ACCESS_REG || aar_size != AAR_SIZE_32) begin
                            cmderr <= CMDERR_NOT_SUPPORTED;
                        end else if (cmd_word[AAR_TRANSFER]) begin
                            if (!regno_ok) cmderr <= CMDERR_EXCEPTION;
                            else if (sel_nonexistent || !sel_halted) begin
                                cmderr <= CMDERR_HALT_RESUME;
                            end else begin
                                state <= CMD_ACCESS;
                            end
                        end
                    end
                end
                CMD_ACCESS: begin
                    if (cmd_write) cmderr <= CMDERR_BUSY;   // Overlapping command
                    if (reg_ack[hart_idx]) state <= CMD_IDLE;
                end
                default: state <= CMD_IDLE;
            endcase
        end
    end

    // Access payload, latched when a command is taken
    always_ff @(posedge clk) begin
        if (cmd_write && (state == CMD_IDLE)) begin
            hart_idx  <= hartsel[HART_IDX_W-1:0];
            reg_write <= cmd_word[AAR_WRITE];
            reg_num   <= regno;
            reg_wdata <= data0;
        end
    end

endmodule

//--- hw/dm_dmi_regs.sv
`timescale 1ns/100ps

module dm_dmi_regs import dm_reg_pkg::*, dm_hart_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  dmi_req_valid,
    input  dmi_op_e               dmi_req_op,
    input  logic [DMI_ADDR_W-1:0] dmi_req_addr,
    input  logic [DMI_DATA_W-1:0] dmi_req_data,
    output logic                  dmi_resp_valid,
    output logic [DMI_DATA_W-1:0] dmi_resp_data,
    output dmi_resp_e             dmi_resp_status,
    input  logic                  sel_halted,
    input  logic                  sel_running,
    input  logic                  sel_resumeack,
    input  logic                  sel_havereset,
    input  logic                  sel_nonexistent,
    input  logic [NUM_HARTS-1:0]  halted_harts,
    input  logic                  busy,
    input  cmderr_e               cmderr,
    input  logic                  data0_load,
    input  logic [DMI_DATA_W-1:0] data0_value,
    output logic                  ctrl_write,
    output logic                  haltreq,
    output logic                  resumereq,
    output logic                  hartreset,
    output logic                  ackhavereset,
    output logic [HARTSEL_W-1:0]  hartsel,
    output logic                  dmactive,
    output logic                  cmd_write,
    output logic [DMI_DATA_W-1:0] cmd_word,
    output logic                  cmderr_clear,
    output logic [DMI_DATA_W-1:0] data0
);

    logic                  wr;
    logic [DMI_DATA_W-1:0] data1;
    logic [DMI_DATA_W-1:0] rd_data;

    assign wr = dmi_req_valid && (dmi_req_op == DMI_WRITE);
    assign dmi_resp_status = DMI_SUCCESS;

    //////////////////////////////////////////////////////////////////////
    // Writable registers
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl_write   <= 1'b0;
            haltreq      <= 1'b0;
            resumereq    <= 1'b0;
            hartreset    <= 1'b0;
            ackhavereset <= 1'b0;
            hartsel      <= '0;
            dmactive     <= 1'b0;
            cmd_write    <= 1'b0;
            cmderr_clear <= 1'b0;
        end else begin
            ctrl_write   <= wr && (dmi_req_addr == DM_CONTROL);
            cmd_write    <= wr && (dmi_req_addr == DM_COMMAND);
            cmderr_clear <= wr && (dmi_req_addr == DM_ABSTRACTCS)
                            && |dmi_req_data[ACS_CMDERR_LSB +: 3];   // W1C
            if (wr && (dmi_req_addr == DM_CONTROL)) begin
                haltreq      <= dmi_req_data[DMC_HALTREQ];
                resumereq    <= dmi_req_data[DMC_RESUMEREQ];
                hartreset    <= dmi_req_data[DMC_HARTRESET];
                ackhavereset <= dmi_req_data[DMC_ACKHAVERESET];
                hartsel      <= dmi_req_data[DMC_HARTSELLO_LSB +: HARTSEL_W];
                dmactive     <= dmi_req_data[DMC_DMACTIVE];
            end
        end
    end

    // Payload only
    always_ff @(posedge clk) begin
        if (wr && (dmi_req_addr == DM_COMMAND)) cmd_word <= dmi_req_data;
        if (wr && (dmi_req_addr == DM_DATA1)) data1 <= dmi_req_data;
        if (wr && (dmi_req_addr == DM_DATA0)) begin
            data0 <= dmi_req_data;   // Debugger wins over a command result
        end else if (data0_load) begin
            data0 <= data0_value;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read mux and response
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        rd_data = '0;
        case (dmi_req_addr)
            DM_DATA0: rd_data = data0;
            DM_DATA1: rd_data = data1;
            DM_CONTROL: begin
                rd_data[DMC_HALTREQ]      = haltreq;
                rd_data[DMC_RESUMEREQ]    = resumereq;
                rd_data[DMC_HARTRESET]    = hartreset;
                rd_data[DMC_ACKHAVERESET] = ackhavereset;
                rd_data[DMC_HARTSELLO_LSB +: HARTSEL_W] = hartsel;
                rd_data[DMC_DMACTIVE]     = dmactive;
            end
            DM_STATUS: begin
                // Single selected hart, so all and any agree
                rd_data[DMS_ALLHAVERESET]   = sel_havereset;
                rd_data[DMS_ANYHAVERESET]   = sel_havereset;
                rd_data[DMS_ALLRESUMEACK]   = sel_resumeack;
                rd_data[DMS_ANYRESUMEACK]   = sel_resumeack;
                rd_data[DMS_ALLNONEXISTENT] = sel_nonexistent;
                rd_data[DMS_ANYNONEXISTENT] = sel_nonexistent;
                rd_data[DMS_ALLRUNNING]     = sel_running;
                rd_data[DMS_ANYRUNNING]     = sel_running;
                rd_data[DMS_ALLHALTED]      = sel_halted;
                rd_data[DMS_ANYHALTED]      = sel_halted;
                rd_data[DMS_AUTHENTICATED]  = 1'b1;   // No authentication
                rd_data[3:0]                = DM_VERSION;
            end
            DM_HARTINFO: rd_data = HARTINFO_VALUE;
            DM_HALTSUM0: rd_data[NUM_HARTS-1:0] = halted_harts;
            DM_ABSTRACTCS: begin
                rd_data[ACS_BUSY]            = busy;
                rd_data[ACS_CMDERR_LSB +: 3] = cmderr;
                rd_data[3:0]                 = DATACOUNT;
            end
            default: rd_data = '0;   // command reads as zero
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dmi_resp_valid <= 1'b0;
        end else begin
            dmi_resp_valid <= dmi_req_valid;
        end
    end

    always_ff @(posedge clk) begin
        dmi_resp_data <= rd_data;
    end

endmodule

//--- hw/dm_hart_ctrl.sv
`timescale 1ns/100ps

module dm_hart_ctrl import dm_hart_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 ctrl_write,
    input  logic                 haltreq,
    input  logic                 resumereq,
    input  logic                 hartreset,
    input  logic                 ackhavereset,
    input  logic [HARTSEL_W-1:0] hartsel,
    input  logic [NUM_HARTS-1:0] running,
    input  logic [NUM_HARTS-1:0] halt_ack,
    input  logic [NUM_HARTS-1:0] resume_ack,
    input  logic [NUM_HARTS-1:0] reset_ack,
    output logic [NUM_HARTS-1:0] halt_req,
    output logic [NUM_HARTS-1:0] resume_req,
    output logic [NUM_HARTS-1:0] reset_req,
    output logic                 sel_halted,
    output logic                 sel_running,
    output logic                 sel_resumeack,
    output logic                 sel_havereset,
    output logic                 sel_nonexistent,
    output logic [NUM_HARTS-1:0] halted_harts
);

    logic                  sel_valid;
    logic [HART_IDX_W-1:0] sel_idx;
    logic [NUM_HARTS-1:0]  sel_mask;
    logic [NUM_HARTS-1:0]  resumeack;
    logic [NUM_HARTS-1:0]  havereset;

    assign sel_valid = (hartsel < NUM_HARTS);
    assign sel_idx = hartsel[HART_IDX_W-1:0];
    assign sel_mask = sel_valid ? (NUM_HARTS'(1) << sel_idx) : '0;

    //////////////////////////////////////////////////////////////////////
    // Per-hart requests and sticky flags
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            halt_req   <= '0;
            resume_req <= '0;
            reset_req  <= '0;
            resumeack  <= '0;
            havereset  <= '0;
        end else begin
            for (int i = 0; i < NUM_HARTS; i++) begin
                if (ctrl_write && sel_mask[i] && haltreq) halt_req[i] <= 1'b1;
                else if (halt_ack[i]) halt_req[i] <= 1'b0;

                if (resume_ack[i]) resumeack[i] <= 1'b1;
                if (ctrl_write && sel_mask[i] && resumereq && !haltreq) begin
                    resume_req[i] <= 1'b1;
                    resumeack[i]  <= 1'b0;   // New resume restarts the handshake
                end else if (resume_ack[i]) begin
                    resume_req[i] <= 1'b0;
                end

                if (ctrl_write && sel_mask[i] && hartreset) reset_req[i] <= 1'b1;
                else if (reset_ack[i] || !hartreset) reset_req[i] <= 1'b0;

                if (reset_ack[i]) havereset[i] <= 1'b1;
                else if (ctrl_write && sel_mask[i] && ackhavereset) havereset[i] <= 1'b0;
            end
        end
    end

    // Status for the selected hart, one cycle behind the harts
    always_ff @(posedge clk) begin
        if (rst) begin
            sel_halted      <= 1'b0;
            sel_running     <= 1'b0;
            sel_resumeack   <= 1'b0;
            sel_havereset   <= 1'b0;
            sel_nonexistent <= 1'b0;
            halted_harts    <= '0;
        end else begin
            sel_halted      <= sel_valid && !running[sel_idx];
            sel_running     <= sel_valid && running[sel_idx];
            sel_resumeack   <= sel_valid && resumeack[sel_idx];
            sel_havereset   <= sel_valid && havereset[sel_idx];
            sel_nonexistent <= !sel_valid;
            halted_harts    <= ~running;
        end
    end

endmodule

//--- hw/dm_hart_pkg.sv
package dm_hart_pkg;

    localparam int NUM_HARTS = 4;
    localparam int HARTSEL_W = 10;   // hartsello only
    localparam int HART_IDX_W = 2;

    localparam int REG_NUM_W = 16;

    // Debug CSRs reachable by access register
    localparam logic [REG_NUM_W-1:0] REG_DCSR = 16'h07b0;
    localparam logic [REG_NUM_W-1:0] REG_DPC = 16'h07b1;
    localparam logic [REG_NUM_W-1:0] REG_DSCRATCH0 = 16'h07b2;
    localparam logic [REG_NUM_W-1:0] REG_DSCRATCH1 = 16'h07b3;

endpackage

//--- hw/dm_reg_pkg.sv
package dm_reg_pkg;

    localparam int DMI_ADDR_W = 7;
    localparam int DMI_DATA_W = 32;

    typedef enum logic [DMI_ADDR_W-1:0] {
        DM_DATA0      = 7'h04,
        DM_DATA1      = 7'h05,
        DM_CONTROL    = 7'h10,
        DM_STATUS     = 7'h11,
        DM_HARTINFO   = 7'h12,
        DM_ABSTRACTCS = 7'h16,
        DM_COMMAND    = 7'h17,
        DM_HALTSUM0   = 7'h40
    } dmi_addr_e;

    typedef enum logic {DMI_READ, DMI_WRITE} dmi_op_e;
    typedef enum logic [1:0] {DMI_SUCCESS = 2'd0} dmi_resp_e;

    localparam logic [3:0] DM_VERSION = 4'd2;   // Spec 0.13
    localparam logic [31:0] HARTINFO_VALUE = 32'h0020_3000;   // nscratch 2, datasize 3
    localparam logic [3:0] DATACOUNT = 4'd2;

    typedef enum logic [2:0] {
        CMDERR_NONE          = 3'd0,
        CMDERR_BUSY          = 3'd1,
        CMDERR_NOT_SUPPORTED = 3'd2,
        CMDERR_EXCEPTION     = 3'd3,
        CMDERR_HALT_RESUME   = 3'd4
    } cmderr_e;

    typedef enum logic [7:0] {
        CMD_ACCESS_REG   = 8'd0,
        CMD_QUICK_ACCESS = 8'd1,
        CMD_ACCESS_MEM   = 8'd2
    } cmd_type_e;

    localparam logic [2:0] AAR_SIZE_32 = 3'd2;

    //////////////////////////////////////////////////////////////////////
    // Field positions
    //////////////////////////////////////////////////////////////////////
    localparam int DMC_HALTREQ = 31;
    localparam int DMC_RESUMEREQ = 30;
    localparam int DMC_HARTRESET = 29;
    localparam int DMC_ACKHAVERESET = 28;
    localparam int DMC_HARTSELLO_LSB = 16;
    localparam int DMC_DMACTIVE = 0;

    localparam int DMS_ALLHAVERESET = 19;
    localparam int DMS_ANYHAVERESET = 18;
    localparam int DMS_ALLRESUMEACK = 17;
    localparam int DMS_ANYRESUMEACK = 16;
    localparam int DMS_ALLNONEXISTENT = 15;
    localparam int DMS_ANYNONEXISTENT = 14;
    localparam int DMS_ALLRUNNING = 11;
    localparam int DMS_ANYRUNNING = 10;
    localparam int DMS_ALLHALTED = 9;
    localparam int DMS_ANYHALTED = 8;
    localparam int DMS_AUTHENTICATED = 7;

    localparam int ACS_BUSY = 12;
    localparam int ACS_CMDERR_LSB = 8;

    localparam int CMD_TYPE_LSB = 24;
    localparam int AAR_SIZE_LSB = 20;
    localparam int AAR_TRANSFER = 17;
    localparam int AAR_WRITE = 16;
    localparam int AAR_REGNO_LSB = 0;

endpackage

//--- run_sim.sh
#!/bin/sh
# Build and run the debug module testbench with Verilator

LOG=sim.log

verilator --binary --timing -Wno-fatal -f vlog.f --top-module debug_module_tb \
    -Mdir obj_dir -o debug_module_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/debug_module_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
    exit 1
fi
exit 0

//--- tb/debug_module_tb.sv
`timescale 1ns/100ps

module debug_module_tb import dm_reg_pkg::*, dm_hart_pkg::*; ();

    localparam int CLK_PERIOD = 10;
    localparam int RESP_LIMIT = 8;     // Cycles to wait for a DMI response
    localparam int POLL_LIMIT = 50;    // Status reads before giving up
    // Roughly 500 DMI transfers of 4 cycles each
    localparam int WATCHDOG_NS = 500 * 4 * CLK_PERIOD;

    logic                  clk = 1'b0;
    logic                  rst = 1'b1;
    logic                  dmi_req_valid = 1'b0;
    dmi_op_e               dmi_req_op = DMI_READ;
    logic [DMI_ADDR_W-1:0] dmi_req_addr = '0;
    logic [DMI_DATA_W-1:0] dmi_req_data = '0;
    logic                  dmi_resp_valid;
    logic [DMI_DATA_W-1:0] dmi_resp_data;
    dmi_resp_e             dmi_resp_status;

    logic [NUM_HARTS-1:0]  halt_req;
    logic [NUM_HARTS-1:0]  halt_ack;
    logic [NUM_HARTS-1:0]  resume_req;
    logic [NUM_HARTS-1:0]  resume_ack;
    logic [NUM_HARTS-1:0]  reset_req;
    logic [NUM_HARTS-1:0]  reset_ack;
    logic [NUM_HARTS-1:0]  running = '1;
    logic [NUM_HARTS-1:0]  reg_req;
    logic [NUM_HARTS-1:0]  reg_ack;
    logic                  reg_write;
    logic [REG_NUM_W-1:0]  reg_num;
    logic [DMI_DATA_W-1:0] reg_wdata;
    logic [NUM_HARTS-1:0][DMI_DATA_W-1:0] reg_rdata = '0;

    int errors = 0;
    int seed = 7177;

    always #(CLK_PERIOD / 2) clk = ~clk;

    debug_module uut (.*);

    //////////////////////////////////////////////////////////////////////
    // Hart model
    //////////////////////////////////////////////////////////////////////
    // Index 0 halt, 1 resume, 2 reset, 3 register access
    logic [NUM_HARTS-1:0]  req_vec [4];
    logic [NUM_HARTS-1:0]  ack_vec [4] = '{default: '0};
    int                    dly [4][NUM_HARTS];
    logic [DMI_DATA_W-1:0] hart_regs [NUM_HARTS][4];

    assign req_vec[0] = halt_req;
    assign req_vec[1] = resume_req;
    assign req_vec[2] = reset_req;
    assign req_vec[3] = reg_req;
    assign halt_ack   = ack_vec[0];
    assign resume_ack = ack_vec[1];
    assign reset_ack  = ack_vec[2];
    assign reg_ack    = ack_vec[3];

    always @(posedge clk) begin
        if (rst) begin
            running <= '1;
            reg_rdata <= '0;
            for (int k = 0; k < 4; k++) begin
                ack_vec[k] <= '0;
                for (int h = 0; h < NUM_HARTS; h++) begin
                    dly[k][h] <= 0;
                    hart_regs[h][k] <= 32'h5a00_0000 | (h << 16) | (32'h07b0 + k);
                end
            end
        end else begin
            for (int k = 0; k < 4; k++) begin
                for (int h = 0; h < NUM_HARTS; h++) begin
                    if (ack_vec[k][h]) begin
                        ack_vec[k][h] <= 1'b0;   // One-cycle acknowledge
                    end else if (req_vec[k][h]) begin
                        if (dly[k][h] == 0) begin
                            dly[k][h] <= 1 + ($unsigned($random(seed)) % 4);
                        end else if (dly[k][h] == 1) begin
                            dly[k][h] <= 0;
                            ack_vec[k][h] <= 1'b1;
                            case (k)
                                0: running[h] <= 1'b0;
                                1: running[h] <= 1'b1;
                                3: begin
                                    if (reg_write) hart_regs[h][reg_num[1:0]] <= reg_wdata;
                                    reg_rdata[h] <= hart_regs[h][reg_num[1:0]];
                                end
                                default: ;
                            endcase
                        end else begin
                            dly[k][h] <= dly[k][h] - 1;
                        end
                    end
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Compare tasks and DMI access
    //////////////////////////////////////////////////////////////////////
    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_cmderr(input string name, input cmderr_e exp, input cmderr_e act);
        if (act !== exp) begin
            errors++;
            $display("ERROR %s: expected %s, actual %s", name, exp.name(), act.name());
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("ERROR %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_resp(input string name, input dmi_resp_e exp, input dmi_resp_e act);
        if (act !== exp) begin
            errors++;
            $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic dmi_transfer(input dmi_op_e op, input dmi_addr_e addr,
                                input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        waited = 0;
        rdata = '0;
        @(posedge clk);
        dmi_req_valid <= 1'b1;
        dmi_req_op    <= op;
        dmi_req_addr  <= addr;
        dmi_req_data  <= wdata;
        @(posedge clk);
        dmi_req_valid <= 1'b0;
        do begin
            @(posedge clk);
            waited++;
        end while (!dmi_resp_valid && waited < RESP_LIMIT);
        if (dmi_resp_valid) begin
            rdata = dmi_resp_data;
            check_resp("dmi response status", DMI_SUCCESS, dmi_resp_status);
        end else begin
            errors++;
            $display("DMI access to %s got no response", addr.name());
        end
    endtask

    task automatic dmi_write(input dmi_addr_e addr, input logic [31:0] wdata);
        logic [31:0] unused;
        dmi_transfer(DMI_WRITE, addr, wdata, unused);
    endtask

    task automatic dmi_read(input dmi_addr_e addr, output logic [31:0] rdata);
        dmi_transfer(DMI_READ, addr, '0, rdata);
    endtask

    task automatic poll_status(input string name, input int bit_pos, input logic exp);
        logic [31:0] rd;
        int tries;
        tries = 0;
        do begin
            dmi_read(DM_STATUS, rd);
            tries++;
        end while (rd[bit_pos] !== exp && tries < POLL_LIMIT);
        if (rd[bit_pos] !== exp) begin
            errors++;
            $display("%s: dmstatus bit %0d never became %b", name, bit_pos, exp);
        end
    endtask

    task automatic expect_cmderr(input string name, input cmderr_e exp);
        logic [31:0] rd;
        int tries;
        tries = 0;
        do begin
            dmi_read(DM_ABSTRACTCS, rd);
            tries++;
        end while (rd[ACS_BUSY] !== 1'b0 && tries < POLL_LIMIT);
        if (rd[ACS_BUSY] !== 1'b0) begin
            errors++;
            $display("%s: abstract command stayed busy", name);
        end
        check_cmderr(name, exp, cmderr_e'(rd[ACS_CMDERR_LSB +: 3]));
    endtask

    function automatic logic [31:0] ctrl_word(input logic halt, input logic resume,
                                              input logic hreset, input logic ackreset,
                                              input int hart);
        logic [31:0] word;
        word = 32'h0000_0001;   // dmactive
        word[DMC_HALTREQ] = halt;
        word[DMC_RESUMEREQ] = resume;
        word[DMC_HARTRESET] = hreset;
        word[DMC_ACKHAVERESET] = ackreset;
        word[DMC_HARTSELLO_LSB +: HARTSEL_W] = hart[HARTSEL_W-1:0];
        return word;
    endfunction

    function automatic logic [31:0] access_reg_cmd(input logic [2:0] size, input logic write,
                                                   input logic [REG_NUM_W-1:0] regno);
        logic [31:0] word;
        word = '0;
        word[CMD_TYPE_LSB +: 8] = CMD_ACCESS_REG;
        word[AAR_SIZE_LSB +: 3] = size;
        word[AAR_TRANSFER] = 1'b1;
        word[AAR_WRITE] = write;
        word[AAR_REGNO_LSB +: REG_NUM_W] = regno;
        return word;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////
    task automatic test_readback();
        logic [31:0] rd;
        dmi_write(DM_DATA0, 32'h1234_5678);
        dmi_write(DM_DATA1, 32'h9abc_def0);
        dmi_write(DM_CONTROL, 32'h0003_0001);   // hartsel 3, dmactive
        dmi_read(DM_DATA0, rd);
        check_word("readback data0", 32'h1234_5678, rd);
        dmi_read(DM_DATA1, rd);
        check_word("readback data1", 32'h9abc_def0, rd);
        dmi_read(DM_CONTROL, rd);
        check_word("readback dmcontrol", 32'h0003_0001, rd);
        dmi_read(DM_HARTINFO, rd);
        check_word("readback hartinfo", (32'd2 << 20) | (32'd3 << 12), rd);
        dmi_read(DM_STATUS, rd);
        check_word("readback version", 32'd2, {28'd0, rd[3:0]});
        check_flag("readback authenticated", 1'b1, rd[7]);
    endtask

    task automatic test_halt_resume();
        logic [31:0] rd;
        dmi_write(DM_CONTROL, ctrl_word(1'b1, 1'b0, 1'b0, 1'b0, 2));
        poll_status("halt allhalted", DMS_ALLHALTED, 1'b1);
        dmi_read(DM_STATUS, rd);
        check_flag("halt anyhalted", 1'b1, rd[DMS_ANYHALTED]);
        dmi_read(DM_HALTSUM0, rd);
        check_word("halt haltsum0", 32'h0000_0004, rd);
        dmi_write(DM_CONTROL, ctrl_word(1'b0, 1'b1, 1'b0, 1'b0, 2));
        poll_status("resume allresumeack", DMS_ALLRESUMEACK, 1'b1);
        dmi_read(DM_STATUS, rd);
        check_flag("resume allrunning", 1'b1, rd[DMS_ALLRUNNING]);
        check_flag("resume anyrunning", 1'b1, rd[DMS_ANYRUNNING]);
    endtask

    task automatic test_reset();
        logic [31:0] rd;
        dmi_write(DM_CONTROL, ctrl_word(1'b0, 1'b0, 1'b1, 1'b0, 0));
        poll_status("reset allhavereset", DMS_ALLHAVERESET, 1'b1);
        dmi_write(DM_CONTROL, ctrl_word(1'b0, 1'b0, 1'b0, 1'b0, 0));
        dmi_read(DM_STATUS, rd);
        check_flag("reset release allhavereset", 1'b1, rd[DMS_ALLHAVERESET]);
        check_flag("reset release anyhavereset", 1'b1, rd[DMS_ANYHAVERESET]);
        dmi_write(DM_CONTROL, ctrl_word(1'b0, 1'b0, 1'b0, 1'b1, 0));
        dmi_read(DM_STATUS, rd);
        check_flag("ackhavereset allhavereset", 1'b0, rd[DMS_ALLHAVERESET]);
    endtask

    task automatic test_nonexistent();
        logic [31:0] rd;
        dmi_write(DM_CONTROL, ctrl_word(1'b0, 1'b0, 1'b0, 1'b0, 5));
        dmi_read(DM_STATUS, rd);
        check_flag("hart 5 allnonexistent", 1'b1, rd[DMS_ALLNONEXISTENT]);
        check_flag("hart 5 anynonexistent", 1'b1, rd[DMS_ANYNONEXISTENT]);
        // Low hartsel bits alias running hart 1
        check_flag("hart 5 allrunning", 1'b0, rd[DMS_ALLRUNNING]);
    endtask

    task automatic test_abstract_access();
        logic [31:0] rd;
        dmi_write(DM_CONTROL, ctrl_word(1'b1, 1'b0, 1'b0, 1'b0, 1));
        poll_status("access halt hart 1", DMS_ALLHALTED, 1'b1);
        dmi_write(DM_DATA0, 32'hcafe_0123);
        dmi_write(DM_COMMAND, access_reg_cmd(AAR_SIZE_32, 1'b1, REG_DPC));
        expect_cmderr("access write cmderr", CMDERR_NONE);
        check_word("access write dpc", 32'hcafe_0123, hart_regs[1][1]);
        dmi_write(DM_DATA0, 32'h0);
        dmi_write(DM_COMMAND, access_reg_cmd(AAR_SIZE_32, 1'b0, REG_DPC));
        expect_cmderr("access read cmderr", CMDERR_NONE);
        dmi_read(DM_DATA0, rd);
        check_word("access read data0", 32'hcafe_0123, rd);
    endtask

    task automatic test_cmd_errors();
        dmi_write(DM_COMMAND, access_reg_cmd(3'd3, 1'b0, REG_DPC));
        expect_cmderr("error wrong size", CMDERR_NOT_SUPPORTED);
        dmi_write(DM_ABSTRACTCS, 32'h0000_0700);
        dmi_write(DM_COMMAND, access_reg_cmd(AAR_SIZE_32, 1'b0, 16'h1000));
        expect_cmderr("error bad regno", CMDERR_EXCEPTION);
        dmi_write(DM_ABSTRACTCS, 32'h0000_0700);
        // Hart 3 was never halted
        dmi_write(DM_CONTROL, ctrl_word(1'b0, 1'b0, 1'b0, 1'b0, 3));
        dmi_write(DM_COMMAND, access_reg_cmd(AAR_SIZE_32, 1'b0, REG_DPC));
        expect_cmderr("error running hart", CMDERR_HALT_RESUME);
        dmi_write(DM_ABSTRACTCS, 32'h0000_0700);
        dmi_write(DM_CONTROL, ctrl_word(1'b0, 1'b0, 1'b0, 1'b0, 1));
        dmi_write(DM_COMMAND, access_reg_cmd(AAR_SIZE_32, 1'b0, REG_DCSR));
        dmi_write(DM_COMMAND, access_reg_cmd(AAR_SIZE_32, 1'b0, REG_DCSR));   // While busy
        expect_cmderr("error overlap", CMDERR_BUSY);
        dmi_write(DM_ABSTRACTCS, 32'hffff_ffff);
        expect_cmderr("error clear", CMDERR_NONE);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Sequence and reporting
    //////////////////////////////////////////////////////////////////////
    initial begin
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        test_readback();
        test_halt_resume();
        test_reset();
        test_nonexistent();
        test_abstract_access();
        test_cmd_errors();
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns with tests still running", WATCHDOG_NS);
        $display("Errors: %0d", errors);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- vlog.f
hw/dm_reg_pkg.sv
hw/dm_hart_pkg.sv
hw/dm_dmi_regs.sv
hw/dm_hart_ctrl.sv
hw/dm_abstract_cmd.sv
hw/debug_module.sv
tb/debug_module_tb.sv
